// File: files.f
+incdir+verilog
verilog/tlb_pkg.sv
verilog/tlb_sweep_counter.sv
verilog/tlb_clear_fsm.sv
verilog/tlb_way_ram.sv
verilog/tlb_lookup.sv
verilog/tlb_miss_fifo.sv
verilog/tlb_top.sv
bench/tlb_tb.sv

// File: bench/tlb_tb.sv
// ==========================================================
// TLB testbench
// Table-driven writes, lookups and flushes with random
// back-pressure on the response and miss ports
// ==========================================================

`include "tlb_macros.svh"

module tlb_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import tlb_pkg::*;

  localparam int TIMEOUT = 400;              // Cycles any single wait may take
  localparam vpn_t VPN_A = 20'h12345;        // Both land in set 5
  localparam vpn_t VPN_B = 20'hABC05;

  typedef enum logic [1:0] {OP_WRITE, OP_LOOKUP, OP_FLUSH, OP_DRAIN_MISS} op_e;

  // One step of the stimulus table with what it must produce
  typedef struct packed {
    op_e         op;
    tlb_wr_t     wr;
    lookup_req_t req;
    logic        exp_miss;                   // Lookup must also show up on the miss port
    lookup_rsp_t rsp;
    miss_t       miss;
  } row_t;

  logic clk = 1'b0;
  logic rst_n_i, lookup_valid_i, lookup_ready_o, rsp_valid_o, rsp_ready_i;
  logic wr_valid_i, wr_ready_o, flush_valid_i, flush_ready_o, miss_valid_o, miss_ready_i;
  lookup_req_t lookup_req_i;
  lookup_rsp_t rsp_o;
  tlb_wr_t wr_i;
  miss_t miss_o;

  row_t stim_q[$];
  lookup_rsp_t exp_rsp_q[$];                 // Responses owed by the DUT, oldest first
  miss_t exp_miss_q[$];
  req_id_t next_id = '0;
  integer seed = 32'he6369b01;
  int errors = 0;
  int rsp_checks = 0;
  int miss_checks = 0;
  logic timed_out = 1'b0;                    // Set once any wait gives up

  always #2 clk = ~clk;

  tlb_top dut_i (.*);

  // Random back-pressure, changed just after every rising edge
  always @(posedge clk) begin
    #1;
    rsp_ready_i  = (($random(seed) & 3) != 0);
    miss_ready_i = (($random(seed) & 1) != 0);
  end

  // ========================================================
  // Compare tasks
  // ========================================================
  task automatic compare_field(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_rsp(lookup_rsp_t got, lookup_rsp_t exp);
    rsp_checks++;
    compare_field("rsp_o.id", 32'(got.id), 32'(exp.id));
    compare_field("rsp_o.hit", 32'(got.hit), 32'(exp.hit));
    compare_field("rsp_o.fault", 32'(got.fault), 32'(exp.fault));
    compare_field("rsp_o.ppn", 32'(got.ppn), 32'(exp.ppn));
  endtask

  task automatic check_miss(miss_t got, miss_t exp);
    miss_checks++;
    compare_field("miss_o.id", 32'(got.id), 32'(exp.id));
    compare_field("miss_o.asid", 32'(got.asid), 32'(exp.asid));
    compare_field("miss_o.vpn", 32'(got.vpn), 32'(exp.vpn));
  endtask

  // Outputs are sampled mid-cycle, a transfer follows on the next rising edge
  always @(negedge clk) begin
    if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
      if (exp_rsp_q.size() == 0) begin
        errors++;
        $display("Response seen while no lookup was outstanding");
      end else begin
        check_rsp(rsp_o, exp_rsp_q.pop_front());
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n_i && miss_valid_o && miss_ready_i) begin
      if (exp_miss_q.size() == 0) begin
        errors++;
        $display("Miss seen that no lookup should have caused");
      end else begin
        check_miss(miss_o, exp_miss_q.pop_front());
      end
    end
  end

  // ========================================================
  // Table building
  // ========================================================
  task automatic write_row(way_t way, logic wr_ok, asid_t asid, vpn_t vpn, ppn_t ppn);
    row_t r;
    r = '0;
    r.op = OP_WRITE;
    r.wr = '{way: way, entry: '{valid: 1'b1, writable: wr_ok, asid: asid, vpn: vpn, ppn: ppn}};
    stim_q.push_back(r);
  endtask

  // Expected hit, fault and ppn come straight from the entries written so far
  task automatic lookup_row(asid_t asid, vpn_t vpn, logic store, logic hit, logic fault,
                            ppn_t ppn);
    row_t r;
    r = '0;
    r.op = OP_LOOKUP;
    r.req = '{id: next_id, asid: asid, vpn: vpn, store: store};
    r.exp_miss = !hit;
    r.rsp = '{id: next_id, hit: hit, fault: fault, ppn: hit ? ppn : '0};
    r.miss = '{id: next_id, asid: asid, vpn: vpn};
    next_id++;
    stim_q.push_back(r);
  endtask

  task automatic plain_row(op_e op);
    row_t r;
    r = '0;
    r.op = op;
    stim_q.push_back(r);
  endtask

  task automatic build_table();
    lookup_row(8'h01, VPN_A, 1'b0, 1'b0, 1'b0, '0);        // Cleared TLB misses
    write_row(1'b0, 1'b1, 8'h01, VPN_A, 16'h1111);
    write_row(1'b1, 1'b0, 8'h02, VPN_B, 16'h2222);          // Read-only entry
    lookup_row(8'h01, VPN_A, 1'b0, 1'b1, 1'b0, 16'h1111);
    lookup_row(8'h02, VPN_B, 1'b0, 1'b1, 1'b0, 16'h2222);
    lookup_row(8'h03, VPN_A, 1'b0, 1'b0, 1'b0, '0);        // Right vpn, wrong asid
    plain_row(OP_DRAIN_MISS);
    lookup_row(8'h02, VPN_B, 1'b1, 1'b1, 1'b1, 16'h2222);  // Store to read-only faults
    lookup_row(8'h02, VPN_B, 1'b0, 1'b1, 1'b0, 16'h2222);
    lookup_row(8'h01, VPN_A, 1'b1, 1'b1, 1'b0, 16'h1111);
    // Burst that overfills the miss queue, a hit every fourth request
    for (int i = 0; i < 2 * `TLB_MISS_DEPTH + 2; i++) begin
      if (i % 4 == 3) lookup_row(8'h01, VPN_A, 1'b0, 1'b1, 1'b0, 16'h1111);
      else            lookup_row(8'h04, 20'h40000 + vpn_t'(i), 1'b0, 1'b0, 1'b0, '0);
    end
    plain_row(OP_DRAIN_MISS);
    plain_row(OP_FLUSH);
    lookup_row(8'h01, VPN_A, 1'b0, 1'b0, 1'b0, '0);        // Gone after the flush
    lookup_row(8'h02, VPN_B, 1'b0, 1'b0, 1'b0, '0);
  endtask

  // ========================================================
  // Drivers, each starts and ends 1 ns after a rising edge
  // ========================================================
  task automatic report_timeout(string what);
    timed_out = 1'b1;
    errors++;
    $display("Timeout: %s", what);
  endtask

  task automatic wait_sweep_done();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!lookup_ready_o && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= TIMEOUT) begin
      report_timeout("lookup port never opened after the sweep");
    end else begin
      if (!wr_ready_o || !flush_ready_o) begin
        errors++;
        $display("Write or flush port still closed after the sweep");
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_write(tlb_wr_t wr);
    int cycles;
    cycles = 0;
    wr_i = wr;
    wr_valid_i = 1'b1;
    @(negedge clk);
    while (!wr_ready_o && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= TIMEOUT) begin
      report_timeout("entry write was never accepted");
    end else begin
      @(posedge clk);
      #1;
    end
    wr_valid_i = 1'b0;
  endtask

  task automatic send_lookup(row_t r);
    int cycles;
    cycles = 0;
    lookup_req_i = r.req;
    lookup_valid_i = 1'b1;
    @(negedge clk);
    while (!lookup_ready_o && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= TIMEOUT) begin
      report_timeout("lookup was never accepted");
    end else begin
      @(posedge clk);
      #1;
      exp_rsp_q.push_back(r.rsp);               // Queued after the edge so monitors never race
      if (r.exp_miss) exp_miss_q.push_back(r.miss);
    end
    lookup_valid_i = 1'b0;
  endtask

  task automatic send_flush();
    int cycles;
    cycles = 0;
    flush_valid_i = 1'b1;
    @(negedge clk);
    while (!flush_ready_o && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= TIMEOUT) begin
      report_timeout("flush was never accepted");
    end else begin
      @(posedge clk);
      #1;
      flush_valid_i = 1'b0;
      @(negedge clk);
      if (lookup_ready_o || wr_ready_o) begin
        errors++;
        $display("Lookup or write port open while the flush sweep runs");
      end
      wait_sweep_done();
    end
  endtask

  // Waits until every owed response and miss has been taken
  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while ((exp_rsp_q.size() != 0 || exp_miss_q.size() != 0) && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (cycles >= TIMEOUT) report_timeout("responses or misses were lost");
  endtask

  // ========================================================
  // Main sequence
  // ========================================================
  initial begin
    rst_n_i = 1'b0;
    lookup_req_i = '0;
    lookup_valid_i = 1'b0;
    rsp_ready_i = 1'b0;
    wr_i = '0;
    wr_valid_i = 1'b0;
    flush_valid_i = 1'b0;
    miss_ready_i = 1'b0;
    build_table();
    repeat (8) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk);
    if (lookup_ready_o || wr_ready_o || flush_ready_o) begin
      errors++;
      $display("Ports open before the reset sweep has run");
    end
    wait_sweep_done();
    foreach (stim_q[i]) begin
      if (!timed_out) begin
        case (stim_q[i].op)
          OP_WRITE:  send_write(stim_q[i].wr);
          OP_LOOKUP: send_lookup(stim_q[i]);
          OP_FLUSH:  send_flush();
          default:   wait_drained();
        endcase
      end
    end
    if (!timed_out) wait_drained();
    $display("Errors: %0d, responses checked: %0d, misses checked: %0d",
             errors, rsp_checks, miss_checks);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/tlb_top.sv
// ==========================================================
// TLB top level
// Ties the clearing sweep, the way RAMs, the lookup pipeline
// and the miss queue together
// ==========================================================

`include "tlb_macros.svh"

module tlb_top (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  tlb_pkg::lookup_req_t lookup_req_i,
  input  logic                 lookup_valid_i,
  output logic                 lookup_ready_o,
  output tlb_pkg::lookup_rsp_t rsp_o,
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i,
  input  tlb_pkg::tlb_wr_t     wr_i,
  input  logic                 wr_valid_i,
  output logic                 wr_ready_o,
  input  logic                 flush_valid_i,
  output logic                 flush_ready_o,
  output tlb_pkg::miss_t       miss_o,
  output logic                 miss_valid_o,
  input  logic                 miss_ready_i
);
  import tlb_pkg::*;

  logic sweeping, sweep_start, sweep_step, sweep_last;
  set_idx_t sweep_idx;
  logic pipe_empty;
  logic lu_ready;                            // Lookup ready before the sweep gate
  logic rd_en;
  set_idx_t rd_idx;
  tlb_entry_t [`TLB_WAYS-1:0] way_rd;        // Read data of every way, same set
  logic [`TLB_WAYS-1:0] way_wr_en;
  set_idx_t wr_idx;
  tlb_entry_t wr_entry;
  miss_t lu_miss;
  logic miss_push, miss_full;

  // Both the write and lookup ports are closed while the sweep owns the RAMs
  assign wr_ready_o     = !sweeping;
  assign lookup_ready_o = lu_ready && !sweeping;

  tlb_clear_fsm clear_i (
    .clk(clk), .rst_n_i(rst_n_i), .flush_valid_i(flush_valid_i), .flush_ready_o(flush_ready_o),
    .pipe_empty_i(pipe_empty), .sweep_last_i(sweep_last), .sweep_start_o(sweep_start),
    .sweep_step_o(sweep_step), .sweeping_o(sweeping));

  tlb_sweep_counter count_i (
    .clk(clk), .rst_n_i(rst_n_i), .start_i(sweep_start), .step_i(sweep_step),
    .index_o(sweep_idx), .last_o(sweep_last));

  // ========================================================
  // Write mux, the sweep clears one set of all ways per cycle
  // ========================================================
  assign wr_idx   = sweep_step ? sweep_idx : wr_i.entry.vpn[`TLB_IDX_BITS-1:0];
  assign wr_entry = sweep_step ? '0 : wr_i.entry;  // All-zero entry has valid low

  for (genvar g = 0; g < `TLB_WAYS; g++) begin : g_way
    assign way_wr_en[g] = sweep_step || (wr_valid_i && !sweeping && wr_i.way == way_t'(g));

    tlb_way_ram ram_i (
      .clk(clk), .wr_en_i(way_wr_en[g]), .wr_idx_i(wr_idx), .wr_entry_i(wr_entry),
      .rd_en_i(rd_en), .rd_idx_i(rd_idx), .rd_entry_o(way_rd[g]));
  end

  tlb_lookup lookup_i (
    .clk(clk), .rst_n_i(rst_n_i), .req_i(lookup_req_i),
    .req_valid_i(lookup_valid_i && !sweeping), .req_ready_o(lu_ready),
    .rd_en_o(rd_en), .rd_idx_o(rd_idx), .ways_i(way_rd),
    .rsp_o(rsp_o), .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i),
    .miss_o(lu_miss), .miss_push_o(miss_push), .miss_full_i(miss_full), .empty_o(pipe_empty));

  tlb_miss_fifo #(.T(miss_t)) miss_fifo_i (
    .clk(clk), .rst_n_i(rst_n_i), .push_i(miss_push), .data_i(lu_miss), .full_o(miss_full),
    .data_o(miss_o), .valid_o(miss_valid_o), .ready_i(miss_ready_i));

endmodule

// File: verilog/tlb_miss_fifo.sv
// ==========================================================
// TLB miss queue
// In-order FIFO of misses for the page-table walker, typed
// so it can hold other payloads
// ==========================================================

`include "tlb_macros.svh"

module tlb_miss_fifo #(
  parameter type T     = tlb_pkg::miss_t,
  parameter int  DEPTH = `TLB_MISS_DEPTH
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic push_i,
  input  T     data_i,
  output logic full_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T mem [DEPTH];
  logic [PW-1:0] wr_ptr, rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic pop;

  assign full_o  = (count == DEPTH);
  assign valid_o = (count != 0);           // Visible one cycle after the push
  assign data_o  = mem[rd_ptr];
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk) begin
    if (push_i) mem[wr_ptr] <= data_i;
  end

  // Pointers wrap by compare so any depth works
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)    rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + push_i - pop;
    end
  end

  // The producer has to honor full, a push here would overwrite the head
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
    full_o |-> !push_i);

  // Head entry holds until the walker takes it
  a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

// File: verilog/tlb_lookup.sv
// ==========================================================
// TLB lookup pipeline
// Stage one reads the ways, stage two compares, selects the
// hit ppn, checks for store faults and issues misses
// ==========================================================

`include "tlb_macros.svh"

module tlb_lookup (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  tlb_pkg::lookup_req_t                req_i,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  output logic                                rd_en_o,      // Read enable of all ways
  output tlb_pkg::set_idx_t                   rd_idx_o,
  input  tlb_pkg::tlb_entry_t [`TLB_WAYS-1:0] ways_i,       // Read data, one per way
  output tlb_pkg::lookup_rsp_t                rsp_o,
  output logic                                rsp_valid_o,
  input  logic                                rsp_ready_i,
  output tlb_pkg::miss_t                      miss_o,
  output logic                                miss_push_o,
  input  logic                                miss_full_i,
  output logic                                empty_o       // Nothing in either stage
);
  import tlb_pkg::*;

  lookup_req_t s1_req;              // Request waiting on the RAM read
  logic s1_valid;
  logic [`TLB_WAYS-1:0] hit_vec;
  logic hit, hit_wr;
  ppn_t hit_ppn;
  logic s2_free, s1_adv, s1_stall;

  // ========================================================
  // Tag compare and hit select
  // ========================================================
  always_comb begin
    hit_ppn = '0;
    hit_wr  = 1'b0;
    for (int w = 0; w < `TLB_WAYS; w++) begin
      hit_vec[w] = ways_i[w].valid && ways_i[w].asid == s1_req.asid &&
                   ways_i[w].vpn == s1_req.vpn;
      if (hit_vec[w]) begin
        hit_ppn |= ways_i[w].ppn;       // OR select, at most one way is set
        hit_wr  |= ways_i[w].writable;
      end
    end
  end
  assign hit = |hit_vec;

  // ========================================================
  // Stall control
  // ========================================================
  assign s2_free  = !rsp_valid_o || rsp_ready_i;                   // Output reg can load
  assign s1_adv   = s1_valid && s2_free && (hit || !miss_full_i);  // A miss needs a free slot
  assign s1_stall = s1_valid && !s1_adv;

  assign req_ready_o = !s1_stall;
  assign rd_en_o     = !s1_stall;            // Keeps the RAM output while stage one waits
  assign rd_idx_o    = req_i.vpn[`TLB_IDX_BITS-1:0];
  assign empty_o     = !s1_valid && !rsp_valid_o;

  // Miss goes to the queue in the same cycle it enters the output register
  assign miss_push_o = s1_adv && !hit;
  assign miss_o      = '{id: s1_req.id, asid: s1_req.asid, vpn: s1_req.vpn};

  // ========================================================
  // Stage one
  // ========================================================
  always_ff @(posedge clk) begin
    if (!rst_n_i) s1_valid <= 1'b0;
    else if (!s1_stall) s1_valid <= req_valid_i;
  end

  always_ff @(posedge clk) begin
    if (!s1_stall) s1_req <= req_i;
  end

  // ========================================================
  // Stage two, the response register
  // ========================================================
  always_ff @(posedge clk) begin
    if (!rst_n_i) rsp_valid_o <= 1'b0;
    else if (s2_free) rsp_valid_o <= s1_adv;  // Bubble when stage one cannot move
  end

  always_ff @(posedge clk) begin
    if (s1_adv) begin
      rsp_o.id    <= s1_req.id;
      rsp_o.hit   <= hit;
      rsp_o.fault <= hit && s1_req.store && !hit_wr;
      rsp_o.ppn   <= hit_ppn;                  // Zero when no way hits
    end
  end

  // The write port must never leave the same translation in two ways
  a_one_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
    s1_valid |-> $onehot0(hit_vec));

endmodule

// File: verilog/tlb_way_ram.sv
// ==========================================================
// TLB way storage
// One way of the TLB, a write port and a registered read
// port, inferred as RAM
// ==========================================================

`include "tlb_macros.svh"

module tlb_way_ram (
  input  logic                clk,
  input  logic                wr_en_i,
  input  tlb_pkg::set_idx_t   wr_idx_i,
  input  tlb_pkg::tlb_entry_t wr_entry_i,
  input  logic                rd_en_i,     // Low holds the read register
  input  tlb_pkg::set_idx_t   rd_idx_i,
  output tlb_pkg::tlb_entry_t rd_entry_o
);
  import tlb_pkg::*;

  tlb_entry_t mem [`TLB_SETS];

  // ========================================================
  // Write port
  // ========================================================
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_idx_i] <= wr_entry_i;
    end
  end

  // ========================================================
  // Read port
  // ========================================================

  // Read-first, a write to the same set shows up on the next read
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_entry_o <= mem[rd_idx_i];
    end
  end

endmodule

// File: verilog/tlb_clear_fsm.sv
// ==========================================================
// TLB clearing machine
// Runs one invalidation sweep after reset and one per flush
// ==========================================================

`include "tlb_macros.svh"

module tlb_clear_fsm (
  input  logic clk,
  input  logic rst_n_i,
  input  logic flush_valid_i,
  output logic flush_ready_o,
  input  logic pipe_empty_i,   // No lookup in flight
  input  logic sweep_last_i,   // Counter sits on the last set
  output logic sweep_start_o,
  output logic sweep_step_o,
  output logic sweeping_o
);

  typedef enum logic [1:0] {
    RESET_WAIT,   // One idle cycle out of reset
    SWEEP,        // Clearing one set per cycle
    IDLE          // Normal operation
  } state_t;

  state_t state, state_nxt;
  logic flush_acc;

  // A flush only goes when no lookup could still read stale entries
  assign flush_ready_o = (state == IDLE) && pipe_empty_i;
  assign flush_acc     = flush_valid_i && flush_ready_o;

  assign sweeping_o    = (state != IDLE);                      // Holds off writes and lookups
  assign sweep_start_o = (state == RESET_WAIT) || flush_acc;  // Counter back to set 0
  assign sweep_step_o  = (state == SWEEP);

  always_comb begin
    state_nxt = state;
    case (state)
      RESET_WAIT: state_nxt = SWEEP;
      SWEEP:      if (sweep_last_i) state_nxt = IDLE;  // Last set is cleared this cycle
      IDLE:       if (flush_acc) state_nxt = SWEEP;
      default:    state_nxt = RESET_WAIT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) state <= RESET_WAIT;
    else          state <= state_nxt;
  end

  // Every accepted flush clears all sets and then reopens the ports
  a_sweep_len: assert property (@(posedge clk) disable iff (!rst_n_i)
    flush_acc |=> sweeping_o [*`TLB_SETS] ##1 !sweeping_o);

endmodule

// File: verilog/tlb_sweep_counter.sv
// ==========================================================
// TLB sweep counter
// Walks the set index for the sweep, flags the last set
// ==========================================================

`include "tlb_macros.svh"

module tlb_sweep_counter (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              start_i,   // Back to set 0
  input  logic              step_i,    // Advance one set
  output tlb_pkg::set_idx_t index_o,
  output logic              last_o
);
  import tlb_pkg::*;

  // Start wins over step so a new sweep always begins at set 0
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      index_o <= '0;
    end else if (start_i) begin
      index_o <= '0;
    end else if (step_i) begin
      index_o <= index_o + 1'b1;  // Wraps to 0 past the last set
    end
  end

  assign last_o = (index_o == set_idx_t'(`TLB_SETS - 1));

endmodule

// File: verilog/tlb_pkg.sv
// ==========================================================
// TLB types
// Packed structs shared by the TLB blocks and the testbench
// ==========================================================

`include "tlb_macros.svh"

package tlb_pkg;

  // ========================================================
  // Basic fields
  // ========================================================
  typedef logic [`TLB_VPN_BITS-1:0]     vpn_t;
  typedef logic [`TLB_PPN_BITS-1:0]     ppn_t;
  typedef logic [`TLB_ASID_BITS-1:0]    asid_t;
  typedef logic [`TLB_ID_BITS-1:0]      req_id_t;
  typedef logic [$clog2(`TLB_WAYS)-1:0] way_t;     // Selects one way on a write
  typedef logic [`TLB_IDX_BITS-1:0]     set_idx_t;

  // ========================================================
  // Stored translation and the write that loads it
  // ========================================================
  typedef struct packed {
    logic    valid;     // Cleared by the sweep
    logic    writable;  // A store to a clear entry faults
    asid_t   asid;
    vpn_t    vpn;       // Full vpn is kept, the index bits included
    ppn_t    ppn;
  } tlb_entry_t;

  typedef struct packed {
    way_t       way;    // The set comes from entry.vpn
    tlb_entry_t entry;
  } tlb_wr_t;

  // ========================================================
  // Lookup traffic
  // ========================================================
  typedef struct packed {
    req_id_t id;
    asid_t   asid;
    vpn_t    vpn;
    logic    store;     // Store access, checked against writable
  } lookup_req_t;

  typedef struct packed {
    req_id_t id;
    logic    hit;
    logic    fault;     // Store that hit a read-only entry
    ppn_t    ppn;       // Zero on a miss
  } lookup_rsp_t;

  // What the page-table walker needs to resolve a miss
  typedef struct packed {
    req_id_t id;
    asid_t   asid;
    vpn_t    vpn;
  } miss_t;

endpackage

// File: verilog/tlb_macros.svh
// ==========================================================
// TLB size macros
// Ways, sets, field widths and the depth of the miss queue
// ==========================================================

`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// Geometry of the set-associative array
`define TLB_WAYS       2   // Ways per set
`define TLB_SETS       16  // Sets in every way
`define TLB_IDX_BITS   4   // Set index taken from the low bits of the vpn

// Field widths of a translation
`define TLB_VPN_BITS   20  // Virtual page number
`define TLB_PPN_BITS   16  // Physical page number
`define TLB_ASID_BITS  8   // Address space id

// Request bookkeeping
`define TLB_ID_BITS    4   // Tag carried from request to response

// Misses waiting for the page-table walker
`define TLB_MISS_DEPTH 4

`endif
